// File: sources.f
logic/ooo_pkg.sv
logic/dispatch_if.sv
logic/register_file.sv
logic/reorder_buffer.sv
logic/reservation_station.sv
logic/alu_unit.sv
logic/multiplier_unit.sv
logic/ooo_core.sv
verification/ooo_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ooo_core testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module ooo_core_tb -f sources.f

./obj_dir/Vooo_core_tb | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// File: verification/ooo_core_tb.sv
`timescale 1ns/1ns

module ooo_core_tb import ooo_pkg::*; ();

  localparam int ISSUE_TIMEOUT = 200;  // cycles
  localparam int DRAIN_TIMEOUT = 500;

  logic    clk_100mhz;
  logic    sys_rst;
  logic    i_issue_valid;
  alu_op_t i_op;
  reg_ix_t i_rd;
  reg_ix_t i_rs1;
  reg_ix_t i_rs2;
  word_t   i_imm;
  logic    i_use_imm;
  logic    o_issue_ready;
  logic    o_commit_valid;
  reg_ix_t o_commit_rd;
  word_t   o_commit_value;

  int      seed;
  word_t   model_regs [NUM_REGS];  // sequential architectural state
  reg_ix_t exp_rd_q [$];
  word_t   exp_val_q [$];
  int      issue_count;
  int      commit_count;
  int      stall_cycles;
  int      checks;
  int      errors;
  int      tests_run;
  int      tests_failed;
  int      errors_at_start;
  int      issued_at_start;

  ooo_core dut_i (
    .i_clk_100mhz   (clk_100mhz),
    .i_sys_rst      (sys_rst),
    .i_issue_valid  (i_issue_valid),
    .i_op           (i_op),
    .i_rd           (i_rd),
    .i_rs1          (i_rs1),
    .i_rs2          (i_rs2),
    .i_imm          (i_imm),
    .i_use_imm      (i_use_imm),
    .o_issue_ready  (o_issue_ready),
    .o_commit_valid (o_commit_valid),
    .o_commit_rd    (o_commit_rd),
    .o_commit_value (o_commit_value)
  );

  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz;
  end

  function automatic int rand_range(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // reference semantics of each op
  function automatic word_t model_op(input alu_op_t op, input word_t a, input word_t b);
    logic [63:0] prod;
    word_t       r;
    case (op)
      OP_ADD: r = a + b;
      OP_SUB: r = a + ~b + 32'd1;
      OP_AND: r = a & b;
      OP_OR:  r = a | b;
      OP_XOR: r = a ^ b;
      OP_SLT: begin
        if (a[31] != b[31]) r = {31'd0, a[31]};  // signs differ, negative one is less
        else r = (a < b) ? 32'd1 : 32'd0;
      end
      OP_SLL: r = a << b[4:0];
      OP_MUL: begin
        prod = {32'd0, a} * {32'd0, b};
        r    = prod[31:0];
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  task automatic check_rd(input reg_ix_t got, input reg_ix_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t: %s got x%0d, expected x%0d", $time, what, got, exp);
    end
  endtask

  task automatic check_value(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERROR t=%0t: %s got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic abort_run(input string why);
    $display("run stopped at %0t: %s", $time, why);
    $display(">>> FAIL");
    $finish;
  endtask

  // executes at acceptance, in program order
  task automatic model_accept(input alu_op_t op, input reg_ix_t rd, input reg_ix_t rs1,
                              input reg_ix_t rs2, input word_t imm, input logic use_imm);
    word_t a;
    word_t b;
    word_t res;
    a   = model_regs[rs1];
    b   = use_imm ? imm : model_regs[rs2];
    res = model_op(op, a, b);
    if (rd != 5'd0) model_regs[rd] = res;  // x0 stays zero
    exp_rd_q.push_back(rd);
    exp_val_q.push_back(res);
    issue_count++;
  endtask

  // called 1 ns after a rising edge, returns 1 ns after the accepting edge
  task automatic issue_instr(input alu_op_t op, input reg_ix_t rd, input reg_ix_t rs1,
                             input reg_ix_t rs2, input word_t imm, input logic use_imm);
    int waited;
    waited        = 0;
    i_issue_valid = 1'b1;
    i_op          = op;
    i_rd          = rd;
    i_rs1         = rs1;
    i_rs2         = rs2;
    i_imm         = imm;
    i_use_imm     = use_imm;
    @(negedge clk_100mhz);
    while (!o_issue_ready && waited < ISSUE_TIMEOUT) begin
      stall_cycles++;
      waited++;
      @(negedge clk_100mhz);
    end
    if (!o_issue_ready) abort_run("issue ready never came back while holding an instruction");
    model_accept(op, rd, rs1, rs2, imm, use_imm);
    @(posedge clk_100mhz);
    #1;
    i_issue_valid = 1'b0;
  endtask

  task automatic issue_random(input int mul_pct, input int reg_span);
    alu_op_t op;
    if (rand_range(100) < mul_pct) op = OP_MUL;
    else op = alu_op_t'(4'(rand_range(7)));
    issue_instr(op, reg_ix_t'(rand_range(reg_span)), reg_ix_t'(rand_range(reg_span)),
                reg_ix_t'(rand_range(reg_span)), word_t'($random(seed)), rand_range(2) == 1);
  endtask

  task automatic drain_all();
    int waited;
    waited = 0;
    while (commit_count != issue_count && waited < DRAIN_TIMEOUT) begin
      waited++;
      @(posedge clk_100mhz);
      #1;
    end
    if (commit_count != issue_count) abort_run("commits stopped before every instruction retired");
  endtask

  task automatic start_test();
    errors_at_start = errors;
    issued_at_start = issue_count;
  endtask

  task automatic end_test(input string name);
    int test_errs;
    test_errs = errors - errors_at_start;
    tests_run++;
    if (test_errs != 0) tests_failed++;
    $display("test %s: %s, %0d issued, %0d errors", name,
             (test_errs == 0) ? "ok" : "failed", issue_count - issued_at_start, test_errs);
  endtask

  // in-order commit checker
  always @(negedge clk_100mhz) begin
    if (!sys_rst && o_commit_valid) begin
      commit_count++;
      if (exp_rd_q.size() == 0) begin
        errors++;
        $display("unexpected commit to x%0d at %0t with nothing outstanding",
                 o_commit_rd, $time);
      end else begin
        check_rd(o_commit_rd, exp_rd_q.pop_front(), "commit rd");
        check_value(o_commit_value, exp_val_q.pop_front(), "commit value");
      end
    end
  end

  task automatic run_reset_check();
    start_test();
    repeat (10) begin
      @(negedge clk_100mhz);
      check_flag(o_commit_valid, 1'b0, "commit while idle");
      check_flag(o_issue_ready, 1'b1, "issue ready while idle");
    end
    @(posedge clk_100mhz);
    #1;
    // sources never written yet, all should read zero
    for (int n = 0; n < 8; n++) begin
      issue_instr(OP_ADD, reg_ix_t'(n + 1), reg_ix_t'(n + 9), reg_ix_t'(n + 17), '0, 1'b0);
    end
    drain_all();
    end_test("reset_state");
  endtask

  task automatic run_alu_random();
    start_test();
    for (int n = 0; n < 200; n++) begin
      issue_random(0, NUM_REGS);
    end
    drain_all();
    end_test("alu_random");
  endtask

  task automatic run_chains();
    reg_ix_t prev1;
    reg_ix_t prev2;
    reg_ix_t rd;
    start_test();
    prev1 = 5'd1;
    prev2 = 5'd2;
    for (int n = 0; n < 40; n++) begin
      rd = reg_ix_t'(rand_range(8));  // x0 is a frequent target
      if (n % 5 == 4) begin
        issue_instr(OP_ADD, rd, 5'd0, 5'd0, '0, 1'b0);
      end else begin
        issue_instr(alu_op_t'(4'(rand_range(8))), rd, prev1, prev2,
                    word_t'($random(seed)), rand_range(4) == 0);
      end
      prev2 = prev1;
      prev1 = rd;
    end
    drain_all();
    end_test("dep_chains");
  endtask

  task automatic run_mixed();
    start_test();
    for (int n = 0; n < 150; n++) begin
      issue_random(35, 16);  // small register span, more hazards
    end
    drain_all();
    end_test("mixed_alu_mul");
  endtask

  task automatic run_backpressure();
    reg_ix_t mul_rd;
    start_test();
    stall_cycles = 0;
    mul_rd       = 5'd9;
    for (int n = 0; n < 16; n++) begin
      if (n % 4 == 3) begin
        issue_instr(OP_ADD, reg_ix_t'(17 + n % 8), mul_rd, 5'd3, '0, 1'b0);
      end else begin
        issue_instr(OP_MUL, reg_ix_t'(9 + n % 4), mul_rd, reg_ix_t'(1 + n % 8), '0, 1'b0);
        mul_rd = reg_ix_t'(9 + n % 4);  // next MUL waits on this one
      end
    end
    check_flag(stall_cycles > 0, 1'b1, "issue ready dropped during burst");
    drain_all();
    // idle window, a stray late commit would land here
    repeat (2 * MUL_LATENCY + 4) begin
      @(posedge clk_100mhz);
      #1;
    end
    check_count(commit_count, issue_count, "commits versus issues");
    check_count(exp_rd_q.size(), 0, "outstanding model entries");
    end_test("back_pressure");
  endtask

  initial begin
    seed            = 52;
    issue_count     = 0;
    commit_count    = 0;
    stall_cycles    = 0;
    checks          = 0;
    errors          = 0;
    tests_run       = 0;
    tests_failed    = 0;
    errors_at_start = 0;
    issued_at_start = 0;
    sys_rst         = 1'b1;
    i_issue_valid   = 1'b0;
    i_op            = OP_ADD;
    i_rd            = '0;
    i_rs1           = '0;
    i_rs2           = '0;
    i_imm           = '0;
    i_use_imm       = 1'b0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    repeat (2) @(posedge clk_100mhz);
    #1;
    sys_rst = 1'b0;

    run_reset_check();
    run_alu_random();
    run_chains();
    run_mixed();
    run_backpressure();

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: logic/ooo_core.sv
`timescale 1ns/1ns

module ooo_core import ooo_pkg::*; (
  input  logic    i_clk_100mhz,
  input  logic    i_sys_rst,
  input  logic    i_issue_valid,
  input  alu_op_t i_op,
  input  reg_ix_t i_rd,
  input  reg_ix_t i_rs1,
  input  reg_ix_t i_rs2,
  input  word_t   i_imm,
  input  logic    i_use_imm,
  output logic    o_issue_ready,
  output logic    o_commit_valid,
  output reg_ix_t o_commit_rd,
  output word_t   o_commit_value
);
  word_t   rf_val1, rf_val2;
  logic    rf_busy1, rf_busy2;
  rob_ix_t rf_tag1, rf_tag2;
  logic    look_done1, look_done2;
  word_t   look_value1, look_value2;
  rob_ix_t alloc_tag;
  rob_ix_t commit_tag;
  logic    rob_full;
  logic    is_mul;
  logic    accept;
  logic    alu_rs_free, mul_rs_free;
  word_t   opnd_a, opnd_b;
  logic    opnd_a_rdy, opnd_b_rdy;

  logic    cdb_valid;
  rob_ix_t cdb_tag;
  word_t   cdb_value;

  logic    alu_fire, alu_ready, alu_valid;
  alu_op_t alu_op;
  word_t   alu_a, alu_b, alu_result;
  rob_ix_t alu_rs_rob_ix, alu_rob_ix;

  logic    mul_fire, mul_ready, mul_valid, mul_grant;
  word_t   mul_a, mul_b, mul_result;
  rob_ix_t mul_rs_rob_ix, mul_rob_ix;

  dispatch_if alu_disp ();
  dispatch_if mul_disp ();

  // issue steering
  assign is_mul        = (i_op == OP_MUL);
  assign o_issue_ready = !rob_full && (is_mul ? mul_rs_free : alu_rs_free);
  assign accept        = i_issue_valid && o_issue_ready;

  // operand from register file, rob forward, or wait on the tag
  always_comb begin
    opnd_a     = rf_val1;
    opnd_a_rdy = 1'b1;
    if (rf_busy1) begin
      opnd_a     = look_value1;
      opnd_a_rdy = look_done1;
    end
    opnd_b     = rf_val2;
    opnd_b_rdy = 1'b1;
    if (i_use_imm) begin
      opnd_b = i_imm;
    end else if (rf_busy2) begin
      opnd_b     = look_value2;
      opnd_b_rdy = look_done2;
    end
  end

  assign alu_disp.valid  = accept && !is_mul;
  assign alu_disp.op     = i_op;
  assign alu_disp.vi     = opnd_a;
  assign alu_disp.vj     = opnd_b;
  assign alu_disp.qi     = rf_tag1;
  assign alu_disp.qj     = rf_tag2;
  assign alu_disp.ri     = opnd_a_rdy;
  assign alu_disp.rj     = opnd_b_rdy;
  assign alu_disp.rob_ix = alloc_tag;

  assign mul_disp.valid  = accept && is_mul;
  assign mul_disp.op     = i_op;
  assign mul_disp.vi     = opnd_a;
  assign mul_disp.vj     = opnd_b;
  assign mul_disp.qi     = rf_tag1;
  assign mul_disp.qj     = rf_tag2;
  assign mul_disp.ri     = opnd_a_rdy;
  assign mul_disp.rj     = opnd_b_rdy;
  assign mul_disp.rob_ix = alloc_tag;

  register_file rf_i (
    .i_clk_100mhz   (i_clk_100mhz),
    .i_sys_rst      (i_sys_rst),
    .i_rs1          (i_rs1),
    .i_rs2          (i_rs2),
    .i_rename       (accept),
    .i_rd           (i_rd),
    .i_rename_tag   (alloc_tag),
    .i_commit       (o_commit_valid),
    .i_commit_rd    (o_commit_rd),
    .i_commit_tag   (commit_tag),
    .i_commit_value (o_commit_value),
    .o_val1         (rf_val1),
    .o_val2         (rf_val2),
    .o_busy1        (rf_busy1),
    .o_busy2        (rf_busy2),
    .o_tag1         (rf_tag1),
    .o_tag2         (rf_tag2)
  );

  reorder_buffer rob_i (
    .i_clk_100mhz   (i_clk_100mhz),
    .i_sys_rst      (i_sys_rst),
    .i_alloc        (accept),
    .i_alloc_rd     (i_rd),
    .i_cdb_valid    (cdb_valid),
    .i_cdb_tag      (cdb_tag),
    .i_cdb_value    (cdb_value),
    .i_look_tag1    (rf_tag1),
    .i_look_tag2    (rf_tag2),
    .o_look_done1   (look_done1),
    .o_look_done2   (look_done2),
    .o_look_value1  (look_value1),
    .o_look_value2  (look_value2),
    .o_alloc_tag    (alloc_tag),
    .o_full         (rob_full),
    .o_commit       (o_commit_valid),
    .o_commit_rd    (o_commit_rd),
    .o_commit_tag   (commit_tag),
    .o_commit_value (o_commit_value)
  );

  reservation_station #(.depth(RS_DEPTH)) alu_rs_i (
    .i_clk_100mhz (i_clk_100mhz),
    .i_sys_rst    (i_sys_rst),
    .disp         (alu_disp),
    .i_cdb_valid  (cdb_valid),
    .i_cdb_tag    (cdb_tag),
    .i_cdb_value  (cdb_value),
    .i_fu_ready   (alu_ready),
    .o_free       (alu_rs_free),
    .o_fire       (alu_fire),
    .o_op         (alu_op),
    .o_a          (alu_a),
    .o_b          (alu_b),
    .o_rob_ix     (alu_rs_rob_ix)
  );

  reservation_station #(.depth(RS_DEPTH)) mul_rs_i (
    .i_clk_100mhz (i_clk_100mhz),
    .i_sys_rst    (i_sys_rst),
    .disp         (mul_disp),
    .i_cdb_valid  (cdb_valid),
    .i_cdb_tag    (cdb_tag),
    .i_cdb_value  (cdb_value),
    .i_fu_ready   (mul_ready),
    .o_free       (mul_rs_free),
    .o_fire       (mul_fire),
    .o_op         (),           // only MUL lands here
    .o_a          (mul_a),
    .o_b          (mul_b),
    .o_rob_ix     (mul_rs_rob_ix)
  );

  alu_unit alu_i (
    .i_clk_100mhz (i_clk_100mhz),
    .i_sys_rst    (i_sys_rst),
    .i_start      (alu_fire),
    .i_op         (alu_op),
    .i_a          (alu_a),
    .i_b          (alu_b),
    .i_rob_ix     (alu_rs_rob_ix),
    .i_grant      (alu_valid),  // ALU always wins the bus
    .o_ready      (alu_ready),
    .o_valid      (alu_valid),
    .o_result     (alu_result),
    .o_rob_ix     (alu_rob_ix)
  );

  multiplier_unit mul_i (
    .i_clk_100mhz (i_clk_100mhz),
    .i_sys_rst    (i_sys_rst),
    .i_start      (mul_fire),
    .i_a          (mul_a),
    .i_b          (mul_b),
    .i_rob_ix     (mul_rs_rob_ix),
    .i_grant      (mul_grant),
    .o_ready      (mul_ready),
    .o_valid      (mul_valid),
    .o_result     (mul_result),
    .o_rob_ix     (mul_rob_ix)
  );

  assign mul_grant = mul_valid && !alu_valid;

  // registered common data bus, granted value shows up next cycle
  always_ff @(posedge i_clk_100mhz) begin
    if (i_sys_rst) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= alu_valid || mul_valid;
    end
  end

  always_ff @(posedge i_clk_100mhz) begin
    cdb_tag   <= alu_valid ? alu_rob_ix : mul_rob_ix;
    cdb_value <= alu_valid ? alu_result : mul_result;
  end

endmodule

// File: logic/multiplier_unit.sv
`timescale 1ns/1ns

module multiplier_unit import ooo_pkg::*; (
  input  logic    i_clk_100mhz,
  input  logic    i_sys_rst,
  input  logic    i_start,
  input  word_t   i_a,
  input  word_t   i_b,
  input  rob_ix_t i_rob_ix,
  input  logic    i_grant,
  output logic    o_ready,
  output logic    o_valid,
  output word_t   o_result,
  output rob_ix_t o_rob_ix
);
  logic                           busy;
  logic [$clog2(MUL_LATENCY)-1:0] cnt;  // busy cycles so far
  logic                           last;
  word_t                          a_q;
  word_t                          b_q;

  assign last    = busy && (cnt == MUL_LATENCY - 2);
  assign o_ready = !busy && (!o_valid || i_grant);

  always_ff @(posedge i_clk_100mhz) begin
    if (i_sys_rst) begin
      busy    <= 1'b0;
      cnt     <= '0;
      o_valid <= 1'b0;
    end else begin
      if (i_grant) o_valid <= 1'b0;
      if (i_start) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (last) begin
        busy    <= 1'b0;
        o_valid <= 1'b1; // held until granted
      end else if (busy) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk_100mhz) begin
    if (i_start) begin
      a_q      <= i_a;
      b_q      <= i_b;
      o_rob_ix <= i_rob_ix;
    end
    if (last) begin
      o_result <= a_q * b_q; // low XLEN bits of the product
    end
  end

endmodule

// File: logic/alu_unit.sv
`timescale 1ns/1ns

module alu_unit import ooo_pkg::*; (
  input  logic    i_clk_100mhz,
  input  logic    i_sys_rst,
  input  logic    i_start,
  input  alu_op_t i_op,
  input  word_t   i_a,
  input  word_t   i_b,
  input  rob_ix_t i_rob_ix,
  input  logic    i_grant,
  output logic    o_ready,
  output logic    o_valid,
  output word_t   o_result,
  output rob_ix_t o_rob_ix
);
  word_t result_d;

  always_comb begin
    case (i_op)
      OP_ADD:  result_d = i_a + i_b;
      OP_SUB:  result_d = i_a - i_b;
      OP_AND:  result_d = i_a & i_b;
      OP_OR:   result_d = i_a | i_b;
      OP_XOR:  result_d = i_a ^ i_b;
      OP_SLT:  result_d = word_t'($signed(i_a) < $signed(i_b));
      OP_SLL:  result_d = i_a << i_b[$clog2(XLEN)-1:0];
      default: result_d = '0; // MUL never reaches this unit
    endcase
  end

  // free again in the cycle the bus takes the held result
  assign o_ready = !o_valid || i_grant;

  always_ff @(posedge i_clk_100mhz) begin
    if (i_sys_rst) begin
      o_valid <= 1'b0;
    end else if (i_start) begin
      o_valid <= 1'b1;
    end else if (i_grant) begin
      o_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk_100mhz) begin
    if (i_start) begin
      o_result <= result_d;
      o_rob_ix <= i_rob_ix;
    end
  end

endmodule

// File: logic/reservation_station.sv
`timescale 1ns/1ns

module reservation_station import ooo_pkg::*; #(
  parameter int depth = RS_DEPTH
) (
  input  logic    i_clk_100mhz,
  input  logic    i_sys_rst,
  dispatch_if.sink disp,
  input  logic    i_cdb_valid,
  input  rob_ix_t i_cdb_tag,
  input  word_t   i_cdb_value,
  input  logic    i_fu_ready,
  output logic    o_free,
  output logic    o_fire,
  output alu_op_t o_op,
  output word_t   o_a,
  output word_t   o_b,
  output rob_ix_t o_rob_ix
);
  typedef logic [$clog2(depth)-1:0] slot_t;

  logic [depth-1:0] valid;
  logic [depth-1:0] ri;
  logic [depth-1:0] rj;
  logic [depth-1:0] rdy;
  logic [depth-1:0] older [depth]; // older[i][j] set when slot j arrived before slot i
  alu_op_t          op     [depth];
  word_t            vi     [depth];
  word_t            vj     [depth];
  rob_ix_t          qi     [depth];
  rob_ix_t          qj     [depth];
  rob_ix_t          rob_ix [depth];
  slot_t            sel_ix;
  slot_t            free_ix;
  logic             any_rdy;

  assign rdy = valid & ri & rj;

  always_comb begin
    sel_ix  = '0;
    free_ix = '0;
    any_rdy = 1'b0;
    for (int i = depth - 1; i >= 0; i--) begin
      if (!valid[i]) free_ix = slot_t'(i); // lowest free slot
    end
    // oldest ready: no other ready entry is older
    for (int i = 0; i < depth; i++) begin
      if (rdy[i] && !(|(rdy & older[i]))) begin
        sel_ix  = slot_t'(i);
        any_rdy = 1'b1;
      end
    end
  end

  assign o_free   = ~&valid;
  assign o_fire   = any_rdy && i_fu_ready;
  assign o_op     = op[sel_ix];
  assign o_a      = vi[sel_ix];
  assign o_b      = vj[sel_ix];
  assign o_rob_ix = rob_ix[sel_ix];

  always_ff @(posedge i_clk_100mhz) begin
    if (i_sys_rst) begin
      valid <= '0;
    end else begin
      if (o_fire) valid[sel_ix] <= 1'b0;
      if (disp.valid) valid[free_ix] <= 1'b1;
    end
  end

  always_ff @(posedge i_clk_100mhz) begin
    for (int i = 0; i < depth; i++) begin
      // wakeup from the bus
      if (valid[i] && i_cdb_valid && !ri[i] && qi[i] == i_cdb_tag) begin
        vi[i] <= i_cdb_value;
        ri[i] <= 1'b1;
      end
      if (valid[i] && i_cdb_valid && !rj[i] && qj[i] == i_cdb_tag) begin
        vj[i] <= i_cdb_value;
        rj[i] <= 1'b1;
      end
      if (disp.valid) older[i][free_ix] <= 1'b0; // newcomer is youngest
    end
    if (disp.valid) begin
      op[free_ix]     <= disp.op;
      vi[free_ix]     <= disp.vi;
      vj[free_ix]     <= disp.vj;
      qi[free_ix]     <= disp.qi;
      qj[free_ix]     <= disp.qj;
      ri[free_ix]     <= disp.ri;
      rj[free_ix]     <= disp.rj;
      rob_ix[free_ix] <= disp.rob_ix;
      older[free_ix]  <= valid;     // everything already here is older
    end
  end

endmodule

// File: logic/reorder_buffer.sv
`timescale 1ns/1ns

module reorder_buffer import ooo_pkg::*; (
  input  logic    i_clk_100mhz,
  input  logic    i_sys_rst,
  input  logic    i_alloc,
  input  reg_ix_t i_alloc_rd,
  input  logic    i_cdb_valid,
  input  rob_ix_t i_cdb_tag,
  input  word_t   i_cdb_value,
  input  rob_ix_t i_look_tag1,
  input  rob_ix_t i_look_tag2,
  output logic    o_look_done1,
  output logic    o_look_done2,
  output word_t   o_look_value1,
  output word_t   o_look_value2,
  output rob_ix_t o_alloc_tag,
  output logic    o_full,
  output logic    o_commit,
  output reg_ix_t o_commit_rd,
  output rob_ix_t o_commit_tag,
  output word_t   o_commit_value
);
  reg_ix_t                     ent_rd    [ROB_DEPTH];
  word_t                       ent_value [ROB_DEPTH];
  logic [ROB_DEPTH-1:0]        ent_done;
  rob_ix_t                     head;
  rob_ix_t                     tail;
  logic [$clog2(ROB_DEPTH):0]  count;
  logic                        bus_hit1;
  logic                        bus_hit2;

  assign o_full      = (count == ROB_DEPTH);
  assign o_alloc_tag = tail;

  // retire the head once its result has landed
  assign o_commit       = (count != '0) && ent_done[head];
  assign o_commit_rd    = ent_rd[head];
  assign o_commit_tag   = head;
  assign o_commit_value = ent_value[head];

  // operand forward, bus value counts in the same cycle
  assign bus_hit1      = i_cdb_valid && (i_cdb_tag == i_look_tag1);
  assign bus_hit2      = i_cdb_valid && (i_cdb_tag == i_look_tag2);
  assign o_look_done1  = ent_done[i_look_tag1] || bus_hit1;
  assign o_look_done2  = ent_done[i_look_tag2] || bus_hit2;
  assign o_look_value1 = bus_hit1 ? i_cdb_value : ent_value[i_look_tag1];
  assign o_look_value2 = bus_hit2 ? i_cdb_value : ent_value[i_look_tag2];

  always_ff @(posedge i_clk_100mhz) begin
    if (i_sys_rst) begin
      head     <= '0;
      tail     <= '0;
      count    <= '0;
      ent_done <= '0;
    end else begin
      if (i_alloc) begin
        ent_done[tail] <= 1'b0;
        tail           <= tail + 1'b1;
      end
      if (i_cdb_valid) begin
        ent_done[i_cdb_tag] <= 1'b1; // complete
      end
      if (o_commit) begin
        head <= head + 1'b1;
      end
      case ({i_alloc, o_commit})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge i_clk_100mhz) begin
    if (i_alloc) begin
      ent_rd[tail] <= i_alloc_rd;
    end
    if (i_cdb_valid) begin
      ent_value[i_cdb_tag] <= i_cdb_value;
    end
  end

endmodule

// File: logic/register_file.sv
`timescale 1ns/1ns

module register_file import ooo_pkg::*; (
  input  logic    i_clk_100mhz,
  input  logic    i_sys_rst,
  input  reg_ix_t i_rs1,
  input  reg_ix_t i_rs2,
  input  logic    i_rename,
  input  reg_ix_t i_rd,
  input  rob_ix_t i_rename_tag,
  input  logic    i_commit,
  input  reg_ix_t i_commit_rd,
  input  rob_ix_t i_commit_tag,
  input  word_t   i_commit_value,
  output word_t   o_val1,
  output word_t   o_val2,
  output logic    o_busy1,
  output logic    o_busy2,
  output rob_ix_t o_tag1,
  output rob_ix_t o_tag2
);
  word_t               regs [NUM_REGS];
  logic [NUM_REGS-1:0] busy;           // a rob entry will write this register
  rob_ix_t             tags [NUM_REGS]; // youngest pending writer

  always_ff @(posedge i_clk_100mhz) begin
    if (i_sys_rst) begin
      busy <= '0;
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (i_commit && i_commit_rd != '0) begin
        regs[i_commit_rd] <= i_commit_value;
        if (tags[i_commit_rd] == i_commit_tag) begin
          busy[i_commit_rd] <= 1'b0; // no younger writer in flight
        end
      end
      // a same-cycle rename overrides the clear above
      if (i_rename && i_rd != '0) begin
        busy[i_rd] <= 1'b1;
        tags[i_rd] <= i_rename_tag;
      end
    end
  end

  // x0 is never written, so it keeps its reset zero
  assign o_val1  = regs[i_rs1];
  assign o_val2  = regs[i_rs2];
  assign o_busy1 = busy[i_rs1];
  assign o_busy2 = busy[i_rs2];
  assign o_tag1  = tags[i_rs1];
  assign o_tag2  = tags[i_rs2];

endmodule

// File: logic/dispatch_if.sv
`timescale 1ns/1ns

// renamed instruction on its way into a reservation station
interface dispatch_if
  import ooo_pkg::*;
();
  logic    valid;
  alu_op_t op;
  word_t   vi;
  word_t   vj;
  rob_ix_t qi;      // producer tags, meaningful while not ready
  rob_ix_t qj;
  logic    ri;
  logic    rj;
  rob_ix_t rob_ix;

  modport source (output valid, op, vi, vj, qi, qj, ri, rj, rob_ix);
  modport sink   (input  valid, op, vi, vj, qi, qj, ri, rj, rob_ix);
endinterface

// File: logic/ooo_pkg.sv
package ooo_pkg;

  localparam int XLEN        = 32;
  localparam int NUM_REGS    = 32;
  localparam int ROB_DEPTH   = 8;  // power of two, rob pointers wrap on their own
  localparam int RS_DEPTH    = 4;
  localparam int MUL_LATENCY = 3;  // at least 2

  // data value
  typedef logic [XLEN-1:0] word_t;

  // architectural register index
  typedef logic [$clog2(NUM_REGS)-1:0] reg_ix_t;

  // rob index, doubles as the rename tag
  typedef logic [$clog2(ROB_DEPTH)-1:0] rob_ix_t;

  // integer ops, MUL is steered to the multiplier
  typedef enum logic [3:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_AND = 4'd2,
    OP_OR  = 4'd3,
    OP_XOR = 4'd4,
    OP_SLT = 4'd5,  // signed compare
    OP_SLL = 4'd6,
    OP_MUL = 4'd7
  } alu_op_t;

endpackage
